// ==== filelist.f ====
design/pipe_pkg.sv
design/exec_stage.sv
design/lsu_unit.sv
design/exec_ctrl_stage.sv
design/wb_stage.sv
design/exec_pipe_top.sv
tb/tb_exec_pipe.sv

// ==== tb/tb_exec_pipe.sv ====
// tb_exec_pipe drives a random operation stream through the pipeline tail and checks each retirement
`timescale 1ns/1ps

module tb_exec_pipe;
   import pipe_pkg::*;

   localparam int N_OPS          = 400;
   localparam int RESET_CYCLES   = 16;
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_OPS * 5 * 4;

   logic    clk = 1'b0;
   logic    rst;
   logic    iss_valid_i;
   logic    iss_ready_o;
   issue_t  iss_i;
   logic    ret_valid_o;
   logic    ret_ready_i;
   retire_t ret_o;

   logic [31:0] rng_state = 32'hc49e44ea;
   pc_t         next_pc   = 32'h0000_1000;
   issue_t      issue_q[$];
   word_t       model_mem [MEM_WORDS];
   logic        model_flag;
   int          issued_cnt  = 0;
   int          retired_cnt = 0;
   int          cycle_cnt   = 0;

   exec_pipe_top UUT (
      .clk         (clk),
      .rst         (rst),
      .iss_valid_i (iss_valid_i),
      .iss_ready_o (iss_ready_o),
      .iss_i       (iss_i),
      .ret_valid_o (ret_valid_o),
      .ret_ready_i (ret_ready_i),
      .ret_o       (ret_o)
   );

   always #20 clk = !clk;

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // memory operations aim at the low 256 bytes and about one in eight is misaligned
   function automatic issue_t make_op();
      issue_t      o;
      logic [31:0] r;
      logic [31:0] r2;
      logic [7:0]  target;
      r  = next_rand();
      r2 = next_rand();
      if (r[3:0] < 4'd12)
         o.op = op_e'(r[3:0]);
      else if (r[3:0] < 4'd14)
         o.op = OP_LW;
      else
         o.op = OP_SW;
      o.pc    = next_pc;
      next_pc = next_pc + 32'd4;
      o.rd    = r[8:4];
      o.rf_wb = (r[11:9] != 3'd0);
      o.opa   = next_rand();
      o.opb   = next_rand();
      o.sdata = next_rand();
      // narrow operands keep most adds and subtracts free of overflow
      if (r[12]) begin
         o.opa = {{16{o.opa[15]}}, o.opa[15:0]};
         o.opb = {{16{o.opb[15]}}, o.opb[15:0]};
      end
      if (o.op == OP_SFEQ && r[13])
         o.opb = o.opa;
      if (o.op == OP_LW || o.op == OP_SW) begin
         target = {r2[7:2], 2'b00};
         if (r[16:14] == 3'd0)
            target[1:0] = (r[18:17] == 2'd0) ? 2'd1 : r[18:17];
         o.opb = {26'd0, r2[13:8]};
         o.opa = {24'd0, target} - o.opb;
      end
      return o;
   endfunction

   // updates the model memory and flag, so calls must come in issue order
   function automatic retire_t expected_retire(input issue_t o);
      retire_t       e;
      logic [XLEN:0] wide;
      word_t         adr;
      e.pc    = o.pc;
      e.op    = o.op;
      e.rd    = o.rd;
      e.exc   = EXC_NONE;
      e.value = '0;
      adr     = o.opa + o.opb;
      case (o.op)
         OP_ADD: begin
            wide    = {o.opa[XLEN-1], o.opa} + {o.opb[XLEN-1], o.opb};
            e.value = wide[XLEN-1:0];
            if (wide[XLEN] != wide[XLEN-1])
               e.exc = EXC_OVERFLOW;
         end
         OP_SUB: begin
            wide    = {o.opa[XLEN-1], o.opa} - {o.opb[XLEN-1], o.opb};
            e.value = wide[XLEN-1:0];
            if (wide[XLEN] != wide[XLEN-1])
               e.exc = EXC_OVERFLOW;
         end
         OP_AND:  e.value = o.opa & o.opb;
         OP_OR:   e.value = o.opa | o.opb;
         OP_XOR:  e.value = o.opa ^ o.opb;
         OP_SHL:  e.value = o.opa << o.opb[4:0];
         OP_SHR:  e.value = o.opa >> o.opb[4:0];
         OP_JAL:  e.value = o.pc + 32'd4;
         OP_SFEQ: model_flag = (o.opa == o.opb);
         OP_LW: begin
            if (adr[1:0] != 2'b00) begin
               e.exc   = EXC_ALIGN;
               e.value = adr;
            end else begin
               e.value = model_mem[adr[MEM_ADR_W+1:2]];
            end
         end
         OP_SW: begin
            e.value = o.sdata;
            if (adr[1:0] != 2'b00)
               e.exc = EXC_ALIGN;
            else
               model_mem[adr[MEM_ADR_W+1:2]] = o.sdata;
         end
         default: e.value = '0;
      endcase
      e.wb_en = o.rf_wb && (e.exc == EXC_NONE) && (o.op != OP_SW);
      e.flag  = model_flag;
      return e;
   endfunction

   task automatic report_mismatch(input string msg);
      $display("MISMATCH at time %0t: %s", $time, msg);
      $display("Simulation FAILED");
      $fatal(1, "run stopped at the first mismatch");
   endtask

   task automatic stop_on_failure(input string msg);
      $display("ERROR at time %0t: %s", $time, msg);
      $display("Simulation FAILED");
      $fatal(1, "run stopped on error");
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp)
         report_mismatch($sformatf("%s got %h expected %h", name, got, exp));
   endtask

   task automatic check_exc(input exc_e got, input exc_e exp);
      if (got !== exp)
         report_mismatch($sformatf("exc got %s expected %s", got.name(), exp.name()));
   endtask

   task automatic check_retire(input retire_t got, input retire_t exp);
      check_word("pc", got.pc, exp.pc);
      if (got.op !== exp.op)
         report_mismatch($sformatf("op at pc %h got %0d expected %0d", exp.pc, got.op, exp.op));
      if (got.rd !== exp.rd)
         report_mismatch($sformatf("rd at pc %h got %0d expected %0d", exp.pc, got.rd, exp.rd));
      if (got.wb_en !== exp.wb_en)
         report_mismatch($sformatf("wb_en at pc %h got %b expected %b", exp.pc, got.wb_en,
                                   exp.wb_en));
      check_word($sformatf("value at pc %h", exp.pc), got.value, exp.value);
      if (got.flag !== exp.flag)
         report_mismatch($sformatf("flag at pc %h got %b expected %b", exp.pc, got.flag,
                                   exp.flag));
      check_exc(got.exc, exp.exc);
   endtask

   // issue valid is held until accepted, and gaps and stalls come from the same random stream
   always @(posedge clk) begin : drive_inputs
      logic [31:0] r;
      if (!rst) begin
         r = next_rand();
         ret_ready_i <= (r[1:0] != 2'd0);
         if (iss_valid_i && iss_ready_o) begin
            issue_q.push_back(iss_i);
            issued_cnt++;
         end
         if (issued_cnt >= N_OPS) begin
            iss_valid_i <= 1'b0;
         end else if (!iss_valid_i || iss_ready_o) begin
            if (r[4:2] != 3'd0) begin
               iss_i       <= make_op();
               iss_valid_i <= 1'b1;
            end else begin
               iss_valid_i <= 1'b0;
            end
         end
      end
   end

   always @(posedge clk) begin : compare_retire
      issue_t  op;
      retire_t exp;
      if (!rst && ret_valid_o && ret_ready_i) begin
         if (issue_q.size() == 0) begin
            stop_on_failure("an operation retired that was never issued");
         end else begin
            op  = issue_q.pop_front();
            exp = expected_retire(op);
            check_retire(ret_o, exp);
            retired_cnt++;
         end
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES)
         stop_on_failure($sformatf("timeout with %0d of %0d operations retired",
                                   retired_cnt, N_OPS));
   end

   initial begin
      rst         = 1'b1;
      iss_valid_i = 1'b0;
      iss_i       = '0;
      ret_ready_i = 1'b0;
      model_flag  = 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         model_mem[i] = '0;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      if (iss_ready_o !== 1'b1 || ret_valid_o !== 1'b0)
         stop_on_failure("handshake outputs are wrong after reset");
      wait (retired_cnt == N_OPS);
      // after a quiet drain every stage is empty and the issue port accepts again
      repeat (20) @(posedge clk);
      if (ret_valid_o === 1'b0 && iss_ready_o === 1'b1) begin
         $display("Simulation PASSED");
         $finish;
      end else begin
         $display("ERROR: the pipeline still holds an operation after the last retirement");
         $display("Simulation FAILED");
         $fatal(1, "pipeline did not drain");
      end
   end

endmodule

// ==== design/exec_pipe_top.sv ====
// exec_pipe_top: execute, execute-control and writeback stages around the load/store unit
`timescale 1ns/1ps

module exec_pipe_top (
   input  logic              clk,
   input  logic              rst,
   input  logic              iss_valid_i,
   output logic              iss_ready_o,
   input  pipe_pkg::issue_t  iss_i,
   output logic              ret_valid_o,
   input  logic              ret_ready_i,
   output pipe_pkg::retire_t ret_o
);
   import pipe_pkg::*;

   logic     ex_valid;
   logic     ex_ready;
   exec_t    ex;
   logic     ct_valid;
   logic     ct_ready;
   exec_t    ct;
   logic     lsu_req;
   logic     lsu_we;
   mem_adr_t lsu_adr;
   word_t    lsu_wdata;
   logic     lsu_done;
   word_t    lsu_rdata;

   exec_stage u_exec (
      .clk         (clk),
      .rst         (rst),
      .in_valid_i  (iss_valid_i),
      .in_ready_o  (iss_ready_o),
      .in_i        (iss_i),
      .out_valid_o (ex_valid),
      .out_ready_i (ex_ready),
      .out_o       (ex)
   );

   exec_ctrl_stage u_ctrl (
      .clk         (clk),
      .rst         (rst),
      .in_valid_i  (ex_valid),
      .in_ready_o  (ex_ready),
      .in_i        (ex),
      .out_valid_o (ct_valid),
      .out_ready_i (ct_ready),
      .out_o       (ct),
      .lsu_req_o   (lsu_req),
      .lsu_we_o    (lsu_we),
      .lsu_adr_o   (lsu_adr),
      .lsu_wdata_o (lsu_wdata),
      .lsu_done_i  (lsu_done),
      .lsu_rdata_i (lsu_rdata)
   );

   lsu_unit u_lsu (
      .clk     (clk),
      .rst     (rst),
      .req_i   (lsu_req),
      .we_i    (lsu_we),
      .adr_i   (lsu_adr),
      .wdata_i (lsu_wdata),
      .done_o  (lsu_done),
      .rdata_o (lsu_rdata)
   );

   wb_stage u_wb (
      .clk         (clk),
      .rst         (rst),
      .in_valid_i  (ct_valid),
      .in_ready_o  (ct_ready),
      .in_i        (ct),
      .out_valid_o (ret_valid_o),
      .out_ready_i (ret_ready_i),
      .out_o       (ret_o)
   );

endmodule

// ==== design/wb_stage.sv ====
// wb_stage: retire register with output handshake and the architectural compare flag
`timescale 1ns/1ps

module wb_stage (
   input  logic              clk,
   input  logic              rst,
   input  logic              in_valid_i,
   output logic              in_ready_o,
   input  pipe_pkg::exec_t   in_i,
   output logic              out_valid_o,
   input  logic              out_ready_i,
   output pipe_pkg::retire_t out_o
);
   import pipe_pkg::*;

   logic flag;
   logic flag_next;
   logic capture;

   // a faulting operation leaves the flag as it was
   always_comb begin
      flag_next = flag;
      if (in_i.exc == EXC_NONE) begin
         if (in_i.flag_set)
            flag_next = 1'b1;
         else if (in_i.flag_clear)
            flag_next = 1'b0;
      end
   end

   assign in_ready_o = !out_valid_o || out_ready_i;
   assign capture    = in_valid_i && in_ready_o;

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid_o <= 1'b0;
         flag        <= 1'b0;
      end else if (capture) begin
         out_valid_o <= 1'b1;
         flag        <= flag_next;
      end else if (out_ready_i) begin
         out_valid_o <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (capture) begin
         out_o.pc    <= in_i.pc;
         out_o.op    <= in_i.op;
         out_o.rd    <= in_i.rd;
         out_o.wb_en <= in_i.rf_wb;
         out_o.value <= in_i.result;
         out_o.flag  <= flag_next;
         out_o.exc   <= in_i.exc;
      end
   end

endmodule

// ==== design/exec_ctrl_stage.sv ====
// exec_ctrl_stage: holds executed operations, runs their memory access and forms the writeback record
`timescale 1ns/1ps

module exec_ctrl_stage (
   input  logic               clk,
   input  logic               rst,
   input  logic               in_valid_i,
   output logic               in_ready_o,
   input  pipe_pkg::exec_t    in_i,
   output logic               out_valid_o,
   input  logic               out_ready_i,
   output pipe_pkg::exec_t    out_o,
   output logic               lsu_req_o,
   output logic               lsu_we_o,
   output pipe_pkg::mem_adr_t lsu_adr_o,
   output pipe_pkg::word_t    lsu_wdata_o,
   input  logic               lsu_done_i,
   input  pipe_pkg::word_t    lsu_rdata_i
);
   import pipe_pkg::*;

   ctrl_state_e state;
   exec_t       rec;
   logic        capture;
   logic        in_mem;
   logic        mem_waiting;

   // a faulting load or store never reaches memory
   assign in_mem = ((in_i.op == OP_LW) || (in_i.op == OP_SW)) &&
                   (in_i.exc == EXC_NONE);

   assign in_ready_o = (state == ST_IDLE) || (state == ST_HOLD && out_ready_i);
   assign capture    = in_valid_i && in_ready_o;

   // the stage is stalled from the request until the unit reports done
   assign mem_waiting = (state == ST_ISSUE) || (state == ST_WAIT && !lsu_done_i);

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: begin
               if (capture)
                  state <= in_mem ? ST_ISSUE : ST_HOLD;
            end
            ST_ISSUE: begin
               state <= ST_WAIT;
            end
            ST_WAIT: begin
               if (!mem_waiting)
                  state <= ST_HOLD;
            end
            ST_HOLD: begin
               if (capture)
                  state <= in_mem ? ST_ISSUE : ST_HOLD;
               else if (out_ready_i)
                  state <= ST_IDLE;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // faults and stores never write the register file
   always_ff @(posedge clk) begin
      if (capture) begin
         rec <= in_i;
         if (in_i.exc != EXC_NONE || in_i.op == OP_SW)
            rec.rf_wb <= 1'b0;
         if (in_i.op == OP_SW)
            rec.result <= in_i.sdata;
      end else if (state == ST_WAIT && lsu_done_i && rec.op == OP_LW) begin
         rec.result <= lsu_rdata_i;
      end
   end

   assign lsu_req_o   = (state == ST_ISSUE);
   assign lsu_we_o    = (rec.op == OP_SW);
   assign lsu_adr_o   = rec.lsu_adr[MEM_ADR_W+1:2];
   assign lsu_wdata_o = rec.sdata;

   assign out_valid_o = (state == ST_HOLD);
   assign out_o       = rec;

endmodule

// ==== design/lsu_unit.sv ====
// lsu_unit: word-wide data memory behind a two-cycle request/done sequencer
`timescale 1ns/1ps

module lsu_unit (
   input  logic               clk,
   input  logic               rst,
   input  logic               req_i,
   input  logic               we_i,
   input  pipe_pkg::mem_adr_t adr_i,
   input  pipe_pkg::word_t    wdata_i,
   output logic               done_o,
   output pipe_pkg::word_t    rdata_o
);
   import pipe_pkg::*;

   word_t      mem [MEM_WORDS];
   lsu_state_e state;
   mem_adr_t   req_adr;
   logic       req_we;
   word_t      req_wdata;

   // the sequencer spends one cycle busy, then pulses done
   always_ff @(posedge clk) begin
      if (rst) begin
         state  <= LSU_IDLE;
         done_o <= 1'b0;
      end else begin
         done_o <= 1'b0;
         case (state)
            LSU_IDLE: begin
               if (req_i)
                  state <= LSU_BUSY;
            end
            LSU_BUSY: begin
               done_o <= 1'b1;
               state  <= LSU_IDLE;
            end
            default: state <= LSU_IDLE;
         endcase
      end
   end

   // a request is latched so the requester may change its outputs afterwards
   always_ff @(posedge clk) begin
      if (state == LSU_IDLE && req_i) begin
         req_adr   <= adr_i;
         req_we    <= we_i;
         req_wdata <= wdata_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] <= '0;
         end
      end else if (state == LSU_BUSY && req_we) begin
         mem[req_adr] <= req_wdata;
      end
   end

   // read data lands together with the done pulse
   always_ff @(posedge clk) begin
      if (state == LSU_BUSY && !req_we)
         rdata_o <= mem[req_adr];
   end

endmodule

// ==== design/exec_stage.sv ====
// exec_stage: computes ALU results, load/store addresses, compare flags and exceptions
`timescale 1ns/1ps

module exec_stage (
   input  logic             clk,
   input  logic             rst,
   input  logic             in_valid_i,
   output logic             in_ready_o,
   input  pipe_pkg::issue_t in_i,
   output logic             out_valid_o,
   input  logic             out_ready_i,
   output pipe_pkg::exec_t  out_o
);
   import pipe_pkg::*;

   word_t adder_res;
   word_t diff_res;
   word_t alu_res;
   logic  ovf;
   logic  misalign;
   exec_t ex_next;

   // the adder serves ADD and the load/store address alike
   assign adder_res = in_i.opa + in_i.opb;
   assign diff_res  = in_i.opa - in_i.opb;

   always_comb begin
      case (in_i.op)
         OP_ADD:  alu_res = adder_res;
         OP_SUB:  alu_res = diff_res;
         OP_AND:  alu_res = in_i.opa & in_i.opb;
         OP_OR:   alu_res = in_i.opa | in_i.opb;
         OP_XOR:  alu_res = in_i.opa ^ in_i.opb;
         OP_SHL:  alu_res = in_i.opa << in_i.opb[4:0];
         OP_SHR:  alu_res = in_i.opa >> in_i.opb[4:0];
         OP_JAL:  alu_res = in_i.pc + 32'd4;
         OP_LW,
         OP_SW:   alu_res = adder_res;
         default: alu_res = '0;
      endcase
   end

   // signed overflow shows as a sign flip that the operand signs cannot explain
   always_comb begin
      ovf = 1'b0;
      if (in_i.op == OP_ADD)
         ovf = (in_i.opa[XLEN-1] == in_i.opb[XLEN-1]) &&
               (adder_res[XLEN-1] != in_i.opa[XLEN-1]);
      else if (in_i.op == OP_SUB)
         ovf = (in_i.opa[XLEN-1] != in_i.opb[XLEN-1]) &&
               (diff_res[XLEN-1] != in_i.opa[XLEN-1]);
   end

   assign misalign = ((in_i.op == OP_LW) || (in_i.op == OP_SW)) &&
                     (adder_res[1:0] != 2'b00);

   always_comb begin
      ex_next.op         = in_i.op;
      ex_next.pc         = in_i.pc;
      ex_next.rd         = in_i.rd;
      ex_next.rf_wb      = in_i.rf_wb;
      ex_next.result     = alu_res;
      ex_next.lsu_adr    = adder_res;
      ex_next.sdata      = in_i.sdata;
      ex_next.flag_set   = (in_i.op == OP_SFEQ) && (in_i.opa == in_i.opb);
      ex_next.flag_clear = (in_i.op == OP_SFEQ) && (in_i.opa != in_i.opb);
      if (ovf)
         ex_next.exc = EXC_OVERFLOW;
      else if (misalign)
         ex_next.exc = EXC_ALIGN;
      else
         ex_next.exc = EXC_NONE;
   end

   // the slot takes a new operation when empty or when its item leaves
   assign in_ready_o = !out_valid_o || out_ready_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid_o <= 1'b0;
      end else if (in_valid_i && in_ready_o) begin
         out_valid_o <= 1'b1;
      end else if (out_ready_i) begin
         out_valid_o <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid_i && in_ready_o)
         out_o <= ex_next;
   end

endmodule

// ==== design/pipe_pkg.sv ====
// pipe_pkg: widths, opcodes, exceptions and stage records shared by the execute pipeline tail
package pipe_pkg;

   localparam int XLEN      = 32;
   localparam int MEM_WORDS = 64;
   localparam int MEM_ADR_W = $clog2(MEM_WORDS);

   typedef logic [XLEN-1:0]      word_t;
   typedef logic [XLEN-1:0]      pc_t;
   typedef logic [4:0]           reg_adr_t;
   typedef logic [MEM_ADR_W-1:0] mem_adr_t;

   typedef enum logic [3:0] {
      OP_NOP  = 4'd0,
      OP_ADD  = 4'd1,
      OP_SUB  = 4'd2,
      OP_AND  = 4'd3,
      OP_OR   = 4'd4,
      OP_XOR  = 4'd5,
      OP_SHL  = 4'd6,
      OP_SHR  = 4'd7,
      OP_SFEQ = 4'd8,
      OP_LW   = 4'd9,
      OP_SW   = 4'd10,
      OP_JAL  = 4'd11
   } op_e;

   typedef enum logic [1:0] {
      EXC_NONE     = 2'd0,
      EXC_OVERFLOW = 2'd1,
      EXC_ALIGN    = 2'd2
   } exc_e;

   // state machines of the load/store unit and of the execute-control stage
   typedef enum logic {
      LSU_IDLE,
      LSU_BUSY
   } lsu_state_e;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ISSUE,
      ST_WAIT,
      ST_HOLD
   } ctrl_state_e;

   // for loads and stores opa is the base and opb the offset
   typedef struct packed {
      op_e      op;
      pc_t      pc;
      reg_adr_t rd;
      logic     rf_wb;
      word_t    opa;
      word_t    opb;
      word_t    sdata;
   } issue_t;

   typedef struct packed {
      op_e      op;
      pc_t      pc;
      reg_adr_t rd;
      logic     rf_wb;
      word_t    result;
      word_t    lsu_adr;
      word_t    sdata;
      logic     flag_set;
      logic     flag_clear;
      exc_e     exc;
   } exec_t;

   // flag holds the compare flag as it stands after this operation
   typedef struct packed {
      pc_t      pc;
      op_e      op;
      reg_adr_t rd;
      logic     wb_en;
      word_t    value;
      logic     flag;
      exc_e     exc;
   } retire_t;

endpackage
